// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP      ?= tb_periph_subsystem
FILELIST ?= sim.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = $(wildcard include/*.svh)
PASS_MSG = Result: PASSED

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/periph_params.svh
// Peripheral subsystem constants
// Clock rate, address map bits, register offsets and reset values

`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Timebase clock in MHz
`define PERIPH_CLK_MHZ          12

// Reset values
`define PERIPH_UART_DIV_RESET   16'd4
`define PERIPH_MTIMECMP_RESET   64'hffff_ffff_ffff_ffff

// Address map bits
`define PERIPH_UNMAPPED_BIT     15
`define PERIPH_UART_BIT         14

// Timer register offsets
`define TMR_CTRL                8'h00
`define TMR_MTIME_LO            8'h08
`define TMR_MTIME_HI            8'h0c
`define TMR_CMP_LO              8'h10
`define TMR_CMP_HI              8'h14

// UART register offsets
`define UART_TXDATA             8'h00
`define UART_STATUS             8'h04
`define UART_CTRL               8'h08
`define UART_DIV                8'h0c

`endif

// File: rtl/apb_periph_decoder.sv
// APB address decoder for the timer and UART
// Slave select, read data, ready and error mux

`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module apb_periph_decoder (
	input  wire periph_bus_pkg::apb_addr_t paddr,
	input  wire                       psel,

	output wire                       timer_psel,
	input  wire periph_bus_pkg::apb_data_t timer_prdata,

	output wire                       uart_psel,
	input  wire periph_bus_pkg::apb_data_t uart_prdata,
	input  wire                       uart_pready,

	output periph_bus_pkg::apb_data_t prdata,
	output logic                      pready,
	output wire                       pslverr
);

	import periph_bus_pkg::*;

	periph_sel_t sel;

	// ------------------------------------------------------------------------
	// Address decode, unmapped space takes priority

	always_comb begin
		if (paddr[`PERIPH_UNMAPPED_BIT])
			sel = SEL_NONE;
		else if (paddr[`PERIPH_UART_BIT])
			sel = SEL_UART;
		else
			sel = SEL_TIMER;
	end

	assign timer_psel = psel && sel == SEL_TIMER;
	assign uart_psel  = psel && sel == SEL_UART;

	// ------------------------------------------------------------------------
	// Response mux

	// Timer and unmapped space always complete at once
	always_comb begin
		case (sel)
			SEL_TIMER: begin
				prdata = timer_prdata;
				pready = 1'b1;
			end
			SEL_UART: begin
				prdata = uart_prdata;
				pready = uart_pready;
			end
			default: begin
				prdata = '0;
				pready = 1'b1;
			end
		endcase
	end

	assign pslverr = psel && sel == SEL_NONE;

endmodule

`default_nettype wire

// File: rtl/periph_bus_pkg.sv
// APB bus types and the decoded slave select

`default_nettype none

package periph_bus_pkg;

	// APB address and data
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Decoded target of an access
	typedef enum logic [1:0] {
		SEL_TIMER,
		SEL_UART,
		SEL_NONE
	} periph_sel_t;

endpackage

`default_nettype wire

// File: rtl/periph_dev_pkg.sv
// Timer and UART types, UART transmit state enum

`default_nettype none

package periph_dev_pkg;

	// Platform timer count
	typedef logic [63:0] mtime_t;

	// UART data byte and bit period
	typedef logic [7:0]  uart_byte_t;
	typedef logic [15:0] uart_div_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} uart_state_t;

endpackage

`default_nettype wire

// File: rtl/periph_subsystem.sv
// Peripheral subsystem top level
// APB decoder with the platform timer and the UART transmitter

`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_subsystem #(
	parameter int clk_mhz = `PERIPH_CLK_MHZ
) (
	input  wire                       clk,
	input  wire                       rst_n,

	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire periph_bus_pkg::apb_addr_t paddr,
	input  wire periph_bus_pkg::apb_data_t pwdata,
	output wire periph_bus_pkg::apb_data_t prdata,
	output wire                       pready,
	output wire                       pslverr,

	input  wire                       dbg_halt,
	output wire                       uart_tx,
	output wire                       timer_irq,
	output wire                       uart_irq
);

	import periph_bus_pkg::*;

	wire       timer_psel;
	wire       uart_psel;
	wire       uart_pready;
	apb_data_t timer_prdata;
	apb_data_t uart_prdata;

	// ------------------------------------------------------------------------
	// Decode

	apb_periph_decoder u_decoder (
		.paddr        (paddr),
		.psel         (psel),
		.timer_psel   (timer_psel),
		.timer_prdata (timer_prdata),
		.uart_psel    (uart_psel),
		.uart_prdata  (uart_prdata),
		.uart_pready  (uart_pready),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	// ------------------------------------------------------------------------
	// Slaves

	riscv_platform_timer #(
		.clk_mhz (clk_mhz)
	) u_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (timer_psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (timer_prdata),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_transmitter u_uart (
		.clk      (clk),
		.rst_n    (rst_n),
		.psel     (uart_psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (uart_prdata),
		.pready   (uart_pready),
		.uart_tx  (uart_tx),
		.uart_irq (uart_irq)
	);

endmodule

`default_nettype wire

// File: rtl/riscv_platform_timer.sv
// RISC-V platform timer on APB
// Microsecond tick divider, mtime/mtimecmp and the level timer interrupt

`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module riscv_platform_timer #(
	parameter int clk_mhz = `PERIPH_CLK_MHZ
) (
	input  wire                       clk,
	input  wire                       rst_n,

	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire periph_bus_pkg::apb_addr_t paddr,
	input  wire periph_bus_pkg::apb_data_t pwdata,
	output periph_bus_pkg::apb_data_t prdata,

	input  wire                       dbg_halt,
	output logic                      timer_irq
);

	import periph_bus_pkg::*;
	import periph_dev_pkg::*;

	localparam int tick_w = (clk_mhz > 1) ? $clog2(clk_mhz) : 1;

	logic [tick_w-1:0] tick_ctr;
	logic              tick;
	logic              timer_en;
	logic              wr_en;
	logic              advance;
	mtime_t            mtime;
	mtime_t            mtimecmp;

	// ------------------------------------------------------------------------
	// Microsecond timebase

	assign tick = (tick_ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
		end else if (tick) begin
			tick_ctr <= tick_w'(clk_mhz - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Registers

	assign wr_en   = psel && penable && pwrite;
	// Count stops while the hart is held by the debugger
	assign advance = tick && timer_en && !dbg_halt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_en <= 1'b1;
		end else if (wr_en && paddr[7:0] == `TMR_CTRL) begin
			timer_en <= pwdata[0];
		end
	end

	// A bus write wins over the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && paddr[7:0] == `TMR_MTIME_LO) begin
			mtime <= {mtime[63:32], pwdata};
		end else if (wr_en && paddr[7:0] == `TMR_MTIME_HI) begin
			mtime <= {pwdata, mtime[31:0]};
		end else if (advance) begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= `PERIPH_MTIMECMP_RESET;
		end else if (wr_en && paddr[7:0] == `TMR_CMP_LO) begin
			mtimecmp <= {mtimecmp[63:32], pwdata};
		end else if (wr_en && paddr[7:0] == `TMR_CMP_HI) begin
			mtimecmp <= {pwdata, mtimecmp[31:0]};
		end
	end

	// Level interrupt, one cycle behind the registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// Read mux
	always_comb begin
		case (paddr[7:0])
			`TMR_CTRL:     prdata = {31'b0, timer_en};
			`TMR_MTIME_LO: prdata = mtime[31:0];
			`TMR_MTIME_HI: prdata = mtime[63:32];
			`TMR_CMP_LO:   prdata = mtimecmp[31:0];
			`TMR_CMP_HI:   prdata = mtimecmp[63:32];
			default:       prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/uart_transmitter.sv
// UART transmitter on APB
// Register block, 8N1 serialiser and TX-idle interrupt

`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module uart_transmitter (
	input  wire                       clk,
	input  wire                       rst_n,

	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire periph_bus_pkg::apb_addr_t paddr,
	input  wire periph_bus_pkg::apb_data_t pwdata,
	output periph_bus_pkg::apb_data_t prdata,
	output wire                       pready,

	output logic                      uart_tx,
	output wire                       uart_irq
);

	import periph_bus_pkg::*;
	import periph_dev_pkg::*;

	uart_state_t state;
	uart_div_t   div;
	uart_div_t   bit_ctr;
	uart_byte_t  shreg;
	logic [2:0]  bit_idx;
	logic        irq_en;
	logic        busy;
	logic        wr_en;
	logic        tx_access;
	logic        accept;
	logic        bit_done;

	// ------------------------------------------------------------------------
	// Bus side

	assign wr_en     = psel && penable && pwrite;
	assign tx_access = wr_en && paddr[7:0] == `UART_TXDATA;
	// Data is taken only from idle, otherwise the access waits
	assign accept    = tx_access && state == ST_IDLE;
	assign pready    = !tx_access || state == ST_IDLE;

	assign busy      = (state != ST_IDLE);
	assign uart_irq  = irq_en && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div    <= `PERIPH_UART_DIV_RESET;
			irq_en <= 1'b0;
		end else if (wr_en) begin
			if (paddr[7:0] == `UART_DIV)
				div <= pwdata[15:0];
			if (paddr[7:0] == `UART_CTRL)
				irq_en <= pwdata[0];
		end
	end

	always_comb begin
		case (paddr[7:0])
			`UART_STATUS: prdata = {31'b0, busy};
			`UART_CTRL:   prdata = {31'b0, irq_en};
			`UART_DIV:    prdata = {16'b0, div};
			default:      prdata = '0;
		endcase
	end

	// ------------------------------------------------------------------------
	// Serialiser

	assign bit_done = (bit_ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			bit_ctr <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state   <= ST_START;
						bit_ctr <= div - 1'b1;
					end
				end
				ST_START: begin
					if (bit_done) begin
						state   <= ST_DATA;
						bit_ctr <= div - 1'b1;
						bit_idx <= '0;
					end else begin
						bit_ctr <= bit_ctr - 1'b1;
					end
				end
				ST_DATA: begin
					if (bit_done) begin
						bit_ctr <= div - 1'b1;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= ST_STOP;
					end else begin
						bit_ctr <= bit_ctr - 1'b1;
					end
				end
				default: begin
					if (bit_done)
						state <= ST_IDLE;
					else
						bit_ctr <= bit_ctr - 1'b1;
				end
			endcase
		end
	end

	// LSB goes out first
	always_ff @(posedge clk) begin
		if (accept)
			shreg <= pwdata[7:0];
		else if (state == ST_DATA && bit_done)
			shreg <= shreg >> 1;
	end

	always_comb begin
		case (state)
			ST_START: uart_tx = 1'b0;
			ST_DATA:  uart_tx = shreg[0];
			default:  uart_tx = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/periph_bus_pkg.sv
rtl/periph_dev_pkg.sv
rtl/riscv_platform_timer.sv
rtl/uart_transmitter.sv
rtl/apb_periph_decoder.sv
rtl/periph_subsystem.sv
verification/tb_periph_subsystem.sv

// File: verification/tb_periph_subsystem.sv
// Testbench for the peripheral subsystem
// APB master tasks, LFSR stimulus, UART frame monitor and assertions

`default_nettype none
`timescale 1ns/1ps
`include "periph_params.svh"

module tb_periph_subsystem;

	import periph_bus_pkg::*;

	localparam apb_addr_t timer_base    = 16'h0000;
	localparam apb_addr_t uart_base     = apb_addr_t'(1 << `PERIPH_UART_BIT);
	localparam apb_addr_t unmapped_base = apb_addr_t'(1 << `PERIPH_UNMAPPED_BIT);
	localparam int        uart_div      = 6;
	localparam int        wait_limit    = 200;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      dbg_halt;
	logic      uart_tx;
	logic      timer_irq;
	logic      uart_irq;

	int          errors;
	int          timeouts;
	int          last_waits;
	logic [31:0] lfsr_state;
	logic [7:0]  expected_bytes[$];

	periph_subsystem #(
		.clk_mhz (4)
	) u_periph_subsystem (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.uart_tx   (uart_tx),
		.timer_irq (timer_irq),
		.uart_irq  (uart_irq)
	);

	always #2 clk = ~clk;

	// --------------------------------------------------------------------------
	// Helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic apb_addr_t reg_addr(input apb_addr_t base, input logic [7:0] offset);
		return base | apb_addr_t'(offset);
	endfunction

	task automatic expect_equal(input string name, input apb_data_t expected,
			input apb_data_t actual);
		assert (actual === expected)
		else begin
			errors++;
			$display("Error: %0t ns %s expected 0x%0h got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else begin
			errors++;
			$display("Error: %0t ns %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	// --------------------------------------------------------------------------
	// APB master tasks that start and end on a falling edge

	task automatic apb_access(input logic is_write, input apb_addr_t addr,
			input apb_data_t wdata, output apb_data_t rdata);
		logic done;
		logic err;
		done       = 1'b0;
		err        = 1'b0;
		rdata      = '0;
		last_waits = 0;
		psel       = 1'b1;
		penable    = 1'b0;
		pwrite     = is_write;
		paddr      = addr;
		pwdata     = wdata;
		@(negedge clk);
		penable = 1'b1;
		while (!done && last_waits < wait_limit) begin
			// Sample mid low phase well away from the rising edge
			#1;
			if (pready) begin
				done  = 1'b1;
				rdata = prdata;
				err   = pslverr;
			end
			@(negedge clk);
			if (!done)
				last_waits++;
		end
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		if (!done) begin
			timeouts++;
			$display("Timeout: APB transfer to address 0x%0h got no pready", addr);
		end else begin
			expect_bit("pslverr", addr[`PERIPH_UNMAPPED_BIT], err);
		end
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t ignored;
		apb_access(1'b1, addr, data, ignored);
	endtask

	task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
		apb_access(1'b0, addr, '0, data);
	endtask

	task automatic wait_uart_idle();
		apb_data_t status;
		int        n;
		n      = 0;
		status = 32'h1;
		while (status[0] && n < wait_limit) begin
			read_reg(reg_addr(uart_base, `UART_STATUS), status);
			n++;
		end
		if (status[0]) begin
			timeouts++;
			$display("Timeout: UART stayed busy");
		end
	endtask

	// --------------------------------------------------------------------------
	// UART frame monitor that samples each bit near its middle

	task automatic receive_frame(input int div);
		logic [7:0] expected;
		int         n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (uart_tx !== 1'b0 && n < wait_limit);
		if (uart_tx !== 1'b0) begin
			timeouts++;
			$display("Timeout: no start bit on uart_tx");
		end else begin
			expected = expected_bytes.pop_front();
			repeat (div / 2) @(negedge clk);
			expect_bit("uart_tx start bit", 1'b0, uart_tx);
			for (int i = 0; i < 8; i++) begin
				repeat (div) @(negedge clk);
				expect_bit($sformatf("uart_tx data bit %0d", i), expected[i], uart_tx);
			end
			repeat (div) @(negedge clk);
			expect_bit("uart_tx stop bit", 1'b1, uart_tx);
		end
	endtask

	// TX-idle interrupt is never up during a start or data bit of value 0
	assert property (@(posedge clk) disable iff (!rst_n) !uart_tx |-> !uart_irq)
	else begin
		errors++;
		$display("Error: %0t ns uart_irq expected 0 got 1 while uart_tx is low", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> pready)
	else begin
		errors++;
		$display("Error: %0t ns pready expected 1 got 0 with pslverr high", $time);
	end

	// --------------------------------------------------------------------------
	// Test sequence

	initial begin
		apb_data_t value;
		apb_data_t first;
		apb_data_t cmp;
		apb_data_t rnd;
		int        n;
		clk        = 1'b0;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		dbg_halt   = 1'b0;
		errors     = 0;
		timeouts   = 0;
		last_waits = 0;
		lfsr_state = 32'h12ab;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Reset values
		expect_bit("uart_tx", 1'b1, uart_tx);
		expect_bit("timer_irq", 1'b0, timer_irq);
		expect_bit("uart_irq", 1'b0, uart_irq);
		expect_bit("pslverr", 1'b0, pslverr);
		read_reg(reg_addr(timer_base, `TMR_MTIME_HI), value);
		expect_equal("mtime_hi", 32'h0, value);
		read_reg(reg_addr(timer_base, `TMR_CMP_LO), value);
		expect_equal("mtimecmp_lo", 32'hffff_ffff, value);
		read_reg(reg_addr(uart_base, `UART_DIV), value);
		expect_equal("uart_div", 32'd4, value);

		// Timer advance and interrupt with a compare value of 3 to 10
		take_bits(3, rnd);
		cmp = 32'd3 + rnd;
		write_reg(reg_addr(timer_base, `TMR_MTIME_HI), 32'h0);
		write_reg(reg_addr(timer_base, `TMR_MTIME_LO), 32'h0);
		write_reg(reg_addr(timer_base, `TMR_CMP_HI), 32'h0);
		write_reg(reg_addr(timer_base, `TMR_CMP_LO), cmp);
		n = 0;
		do begin
			read_reg(reg_addr(timer_base, `TMR_MTIME_LO), value);
			if (value < cmp)
				expect_bit("timer_irq below compare", 1'b0, timer_irq);
			n++;
		end while (!timer_irq && n < wait_limit);
		if (!timer_irq) begin
			timeouts++;
			$display("Timeout: timer_irq never rose");
		end
		read_reg(reg_addr(timer_base, `TMR_MTIME_LO), value);
		assert (value >= cmp)
		else begin
			errors++;
			$display("Error: %0t ns mtime_lo expected >= %0d got %0d", $time, cmp, value);
		end
		write_reg(reg_addr(timer_base, `TMR_CMP_LO), 32'hffff_ffff);
		write_reg(reg_addr(timer_base, `TMR_CMP_HI), 32'hffff_ffff);
		@(negedge clk);
		expect_bit("timer_irq after compare reload", 1'b0, timer_irq);

		// Debug freeze
		dbg_halt = 1'b1;
		read_reg(reg_addr(timer_base, `TMR_MTIME_LO), first);
		repeat (3 * 4) @(negedge clk);
		read_reg(reg_addr(timer_base, `TMR_MTIME_LO), value);
		expect_equal("mtime_lo while halted", first, value);
		dbg_halt = 1'b0;
		repeat (3 * 4) @(negedge clk);
		read_reg(reg_addr(timer_base, `TMR_MTIME_LO), rnd);
		assert (rnd > value)
		else begin
			errors++;
			$display("Error: %0t ns mtime_lo expected > %0d got %0d", $time, value, rnd);
		end

		// Single UART frame
		write_reg(reg_addr(uart_base, `UART_DIV), uart_div);
		take_bits(8, rnd);
		expected_bytes.push_back(rnd[7:0]);
		fork
			write_reg(reg_addr(uart_base, `UART_TXDATA), rnd);
			receive_frame(uart_div);
		join
		wait_uart_idle();

		// Back-pressure on a second byte and the TX-idle interrupt
		write_reg(reg_addr(uart_base, `UART_CTRL), 32'h1);
		expect_bit("uart_irq when idle", 1'b1, uart_irq);
		take_bits(8, first);
		take_bits(8, rnd);
		expected_bytes.push_back(first[7:0]);
		expected_bytes.push_back(rnd[7:0]);
		fork
			begin
				write_reg(reg_addr(uart_base, `UART_TXDATA), first);
				read_reg(reg_addr(uart_base, `UART_STATUS), value);
				expect_equal("uart_status", 32'h1, value);
				expect_bit("uart_irq while busy", 1'b0, uart_irq);
				write_reg(reg_addr(uart_base, `UART_TXDATA), rnd);
				assert (last_waits > 0)
				else begin
					errors++;
					$display("Error: %0t ns pready expected 0 got 1 on TXDATA write while busy",
						$time);
				end
			end
			begin
				receive_frame(uart_div);
				receive_frame(uart_div);
			end
		join
		expect_bit("uart_irq in stop bit", 1'b0, uart_irq);
		wait_uart_idle();
		expect_bit("uart_irq after frames", 1'b1, uart_irq);

		// Unmapped space where the unmapped bit wins over the UART bit
		read_reg(reg_addr(unmapped_base, `TMR_MTIME_LO), value);
		expect_equal("unmapped prdata", 32'h0, value);
		read_reg(reg_addr(unmapped_base | uart_base, `UART_DIV), value);
		expect_equal("unmapped prdata", 32'h0, value);
		apb_access(1'b1, reg_addr(unmapped_base | uart_base, `UART_DIV), 32'h1234, value);
		expect_equal("unmapped prdata on write", 32'h0, value);
		write_reg(reg_addr(unmapped_base, `TMR_CMP_LO), 32'h0);
		read_reg(reg_addr(uart_base, `UART_DIV), value);
		expect_equal("uart_div after unmapped write", 32'd6, value);
		read_reg(reg_addr(timer_base, `TMR_CMP_LO), value);
		expect_equal("mtimecmp_lo after unmapped write", 32'hffff_ffff, value);

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
